// ==== src/ethernetIo_macros.svh ====
//**********************************************************
// KSZ8851 constants
// Register map, init values, chip ID, bit positions, frame layout
//**********************************************************
`ifndef ETHERNETIO_MACROS_SVH
`define ETHERNETIO_MACROS_SVH

// Register addresses
`define ETH_REG_CHIPID   8'hC0
`define ETH_REG_MARL     8'h10   // MAC address low
`define ETH_REG_MARM     8'h12
`define ETH_REG_MARH     8'h14
`define ETH_REG_TXCR     8'h70   // Transmit control
`define ETH_REG_RXCR1    8'h74   // Receive control 1
`define ETH_REG_RXFHSR   8'h7C   // Receive frame header status
`define ETH_REG_RXFHBCR  8'h7E   // Receive frame header byte count
`define ETH_REG_RXQCR    8'h82   // RXQ command
`define ETH_REG_TXFDPR   8'h84
`define ETH_REG_RXFDPR   8'h86
`define ETH_REG_IER      8'h90
`define ETH_REG_ISR      8'h92
`define ETH_REG_RXFCTR   8'h9C   // Frame count and threshold

// Values written during initialization
`define ETH_MAC_LOW      16'h9400
`define ETH_MAC_MID      16'h0E13
`define ETH_MAC_HIGH     16'hFA61
`define ETH_INIT_TXFDPR  16'h4000   // TX frame pointer auto increment
`define ETH_INIT_TXCR    16'h01EE   // TX flow control, CRC and padding
`define ETH_INIT_RXFDPR  16'h5000   // RX frame pointer auto increment, pointer 0
`define ETH_INIT_RXFCTR  16'h0001   // Threshold of one frame
`define ETH_INIT_RXCR1   16'h7CE0   // Checksums, filtering, broadcast/multicast/unicast
`define ETH_INIT_RXQCR   16'h0020   // Frame count threshold, no auto-dequeue
`define ETH_INIT_ISR     16'hFFFF   // Clear all pending interrupts
`define ETH_INIT_IER     16'h2000   // Receive interrupt only
`define ETH_INIT_WRITES  11

`define ETH_CHIPID       12'h887

// Bit positions
`define ETH_BIT_RXIS         13
`define ETH_BIT_FRAME_VALID  15
`define ETH_BIT_DMA          3
`define ETH_BIT_FLUSH        0

// DMA frame layout in words
`define ETH_SKIP_WORDS    3
`define ETH_HEADER_WORDS  7
`define ETH_LEN_QREAD     16'd16
`define ETH_LEN_QWRITE    16'd20

`endif

// ==== src/ethernetIoPkg.sv ====
//**********************************************************
// Ethernet I/O types
// Chip words, register addresses and the enums of the KSZ8851 sequencer
//**********************************************************
package ethernetIoPkg;

    typedef logic [15:0] word_t;      // KSZ8851 data word
    typedef logic [7:0]  regAddr_t;   // KSZ8851 register address

    // Command kinds carried by the command port
    typedef enum logic [1:0] {
        regRead,
        regWrite,
        dmaRead
    } cmdKind_e;

    // Classification from the header length word
    typedef enum logic [1:0] {
        quadReadFrame,
        quadWriteFrame,
        otherFrame
    } frameClass_e;

    typedef enum logic [4:0] {
        seqIdle,
        seqWaitDone,      // Command in flight, waiting for done
        // Initialization
        seqChipId,
        seqInitWrite,
        seqTxEnRead,
        seqTxEnWrite,
        seqRxEnRead,
        seqRxEnWrite,
        seqInitDone,
        // Receive service
        seqIsrCheck,
        seqFrameCount,
        seqCountCheck,
        seqFrameStatus,
        seqStatusCheck,
        seqFrameLength,
        seqDmaRead,
        seqDmaSet,
        seqDmaWord,
        seqFlushRead,
        seqFlushWrite
    } seqState_e;

endpackage

// ==== src/ethFrameDecoder.sv ====
//**********************************************************
// DMA header decoder
// Counts header words and classifies the frame by its length word
//**********************************************************
`timescale 1ns/1ps
`include "ethernetIo_macros.svh"

module ethFrameDecoder (
    input  logic                 sysclk,
    input  logic                 reset,
    input  logic                 frameStart,
    input  logic                 done,
    input  logic                 dmaWord,
    input  ethernetIoPkg::word_t readWord,
    output logic                 headerDone,
    output logic                 quadRead,
    output logic                 quadWrite
);
    import ethernetIoPkg::*;

    logic [3:0]  wordCount;    // DMA words seen since frameStart
    logic        lengthWord;   // Current DMA word is the length word
    frameClass_e frameClass;

    assign lengthWord = done && dmaWord && !headerDone
                        && (wordCount == 4'(`ETH_SKIP_WORDS + `ETH_HEADER_WORDS - 1));

    always_comb
    begin
        if (readWord == `ETH_LEN_QREAD)
            frameClass = quadReadFrame;
        else if (readWord == `ETH_LEN_QWRITE)
            frameClass = quadWriteFrame;
        else
            frameClass = otherFrame;
    end

    always_ff @(posedge sysclk or negedge reset)
    begin
        if (!reset)
        begin
            wordCount  <= '0;
            headerDone <= 1'b0;
            quadRead   <= 1'b0;
            quadWrite  <= 1'b0;
        end
        else if (frameStart)
        begin
            wordCount  <= '0;
            headerDone <= 1'b0;
        end
        else if (done && dmaWord && !headerDone)
        begin
            wordCount <= wordCount + 4'd1;
            if (lengthWord)
            begin
                headerDone <= 1'b1;
                if (frameClass == quadReadFrame)
                    quadRead <= ~quadRead;
                if (frameClass == quadWriteFrame)
                    quadWrite <= ~quadWrite;
            end
        end
    end

endmodule

// ==== src/ethCommandPort.sv ====
//**********************************************************
// KSZ8851 command port
// Carries one register or DMA command over the cmdReq/cmdAck handshake
//**********************************************************
`timescale 1ns/1ps

module ethCommandPort (
    input  logic                    sysclk,
    input  logic                    reset,
    input  logic                    start,
    input  ethernetIoPkg::cmdKind_e cmdKind,
    input  ethernetIoPkg::regAddr_t cmdAddr,
    input  ethernetIoPkg::word_t    cmdData,
    input  logic                    cmdAck,
    input  logic                    readValid,
    input  ethernetIoPkg::word_t    ReadData,
    output logic                    busy,
    output logic                    done,
    output logic                    dmaWord,
    output logic                    cmdReq,
    output logic                    isDMA,
    output logic                    isWrite,
    output logic                    isWord,
    output ethernetIoPkg::regAddr_t RegAddr,
    output ethernetIoPkg::word_t    WriteData,
    output ethernetIoPkg::word_t    readWord
);
    import ethernetIoPkg::*;

    typedef enum logic [1:0] {
        portIdle,
        portWaitAck,
        portWaitAckClear,
        portWaitRead
    } portState_e;

    portState_e state;
    logic       finish;   // Command completes this cycle

    assign busy   = (state != portIdle);
    assign isWord = 1'b1;   // All transfers are words

    // A write ends when cmdAck drops, a read when its data is valid after that
    always_comb
    begin
        finish = 1'b0;
        if (state == portWaitAckClear && !cmdAck)
            finish = isWrite || readValid;
        else if (state == portWaitRead)
            finish = readValid;
    end

    always_ff @(posedge sysclk or negedge reset)
    begin
        if (!reset)
        begin
            state   <= portIdle;
            cmdReq  <= 1'b0;
            isDMA   <= 1'b0;
            isWrite <= 1'b0;
            done    <= 1'b0;
            dmaWord <= 1'b0;
        end
        else
        begin
            done    <= finish;
            dmaWord <= finish && isDMA;
            case (state)
                portIdle:
                    if (start)
                    begin
                        cmdReq  <= 1'b1;
                        isDMA   <= (cmdKind == dmaRead);
                        isWrite <= (cmdKind == regWrite);
                        state   <= portWaitAck;
                    end
                portWaitAck:
                    if (cmdAck)
                    begin
                        cmdReq <= 1'b0;   // Drop request once accepted
                        state  <= portWaitAckClear;
                    end
                portWaitAckClear:
                    if (!cmdAck)
                        state <= finish ? portIdle : portWaitRead;
                default:
                    if (readValid)
                        state <= portIdle;
            endcase
        end
    end

    // Address, write data and read result
    always_ff @(posedge sysclk)
    begin
        if (start && state == portIdle)
        begin
            RegAddr   <= cmdAddr;
            WriteData <= cmdData;
        end
        if (finish && !isWrite)
            readWord <= ReadData;
    end

endmodule

// ==== src/ethSequencer.sv ====
//**********************************************************
// KSZ8851 sequencer
// Chip init and receive interrupt service, one command at a time
//**********************************************************
`timescale 1ns/1ps
`include "ethernetIo_macros.svh"

module ethSequencer (
    input  logic                    sysclk,
    input  logic                    reset,
    input  logic                    initReq,
    input  logic                    ETH_IRQn,
    input  logic                    receiveEnabled,
    input  logic                    busy,
    input  logic                    done,
    input  ethernetIoPkg::word_t    readWord,
    input  logic                    headerDone,
    output logic                    initAck,
    output logic                    initOK,
    output logic                    start,
    output logic                    frameStart,
    output ethernetIoPkg::cmdKind_e cmdKind,
    output ethernetIoPkg::regAddr_t cmdAddr,
    output ethernetIoPkg::word_t    cmdData
);
    import ethernetIoPkg::*;

    seqState_e   state;
    seqState_e   retState;     // Where to go when the command completes
    logic [3:0]  initIdx;      // Position in the init write table
    logic [7:0]  frameCount;   // Frames left to service
    logic [23:0] initEntry;    // {address, value}

    always_comb
    begin
        case (initIdx)
            4'd0:    initEntry = {`ETH_REG_MARL, `ETH_MAC_LOW};
            4'd1:    initEntry = {`ETH_REG_MARM, `ETH_MAC_MID};
            4'd2:    initEntry = {`ETH_REG_MARH, `ETH_MAC_HIGH};
            4'd3:    initEntry = {`ETH_REG_TXFDPR, `ETH_INIT_TXFDPR};
            4'd4:    initEntry = {`ETH_REG_TXCR, `ETH_INIT_TXCR};
            4'd5:    initEntry = {`ETH_REG_RXFDPR, `ETH_INIT_RXFDPR};
            4'd6:    initEntry = {`ETH_REG_RXFCTR, `ETH_INIT_RXFCTR};
            4'd7:    initEntry = {`ETH_REG_RXCR1, `ETH_INIT_RXCR1};
            4'd8:    initEntry = {`ETH_REG_RXQCR, `ETH_INIT_RXQCR};
            4'd9:    initEntry = {`ETH_REG_ISR, `ETH_INIT_ISR};
            default: initEntry = {`ETH_REG_IER, `ETH_INIT_IER};
        endcase
    end

    // Hand one command to the command port and wait for its done
    task automatic issueCmd(input cmdKind_e kind, input regAddr_t addr, input word_t data,
                            input seqState_e ret);
        start    <= 1'b1;
        cmdKind  <= kind;
        cmdAddr  <= addr;
        cmdData  <= data;
        retState <= ret;
        state    <= seqWaitDone;
    endtask

    always_ff @(posedge sysclk or negedge reset)
    begin
        if (!reset)
        begin
            state      <= seqIdle;
            retState   <= seqIdle;
            initIdx    <= '0;
            frameCount <= '0;
            initAck    <= 1'b0;
            initOK     <= 1'b0;
            start      <= 1'b0;
            frameStart <= 1'b0;
            cmdKind    <= regRead;
            cmdAddr    <= '0;
            cmdData    <= '0;
        end
        else
        begin
            start      <= 1'b0;
            frameStart <= 1'b0;
            case (state)
                seqIdle:
                    if (initReq && !initAck)   // Init wins over the interrupt
                    begin
                        initAck <= 1'b1;
                        initOK  <= 1'b0;
                        issueCmd(regRead, `ETH_REG_CHIPID, '0, seqChipId);
                    end
                    else if (!ETH_IRQn && receiveEnabled)
                        issueCmd(regRead, `ETH_REG_ISR, '0, seqIsrCheck);
                seqWaitDone:
                    if (done && !busy)
                        state <= retState;
                seqChipId:
                begin
                    initAck <= 1'b0;
                    initIdx <= '0;
                    state   <= (readWord[15:4] == `ETH_CHIPID) ? seqInitWrite : seqIdle;
                end
                seqInitWrite:
                begin
                    initIdx <= initIdx + 4'd1;
                    issueCmd(regWrite, initEntry[23:16], initEntry[15:0],
                             (initIdx == 4'(`ETH_INIT_WRITES - 1)) ? seqTxEnRead : seqInitWrite);
                end
                seqTxEnRead:
                    issueCmd(regRead, `ETH_REG_TXCR, '0, seqTxEnWrite);
                seqTxEnWrite:
                    issueCmd(regWrite, `ETH_REG_TXCR, {readWord[15:1], 1'b1}, seqRxEnRead);
                seqRxEnRead:
                    issueCmd(regRead, `ETH_REG_RXCR1, '0, seqRxEnWrite);
                seqRxEnWrite:
                    issueCmd(regWrite, `ETH_REG_RXCR1, {readWord[15:1], 1'b1}, seqInitDone);
                seqInitDone:
                begin
                    initOK <= 1'b1;
                    state  <= seqIdle;
                end
                seqIsrCheck:
                    if (readWord[`ETH_BIT_RXIS])   // Write 1 to clear RXIS
                        issueCmd(regWrite, `ETH_REG_ISR, readWord | (16'd1 << `ETH_BIT_RXIS),
                                 seqFrameCount);
                    else
                        state <= seqIdle;
                seqFrameCount:
                    issueCmd(regRead, `ETH_REG_RXFCTR, '0, seqCountCheck);
                seqCountCheck:
                begin
                    frameCount <= readWord[15:8];
                    state      <= (readWord[15:8] == 8'd0) ? seqIdle : seqFrameStatus;
                end
                seqFrameStatus:
                    issueCmd(regRead, `ETH_REG_RXFHSR, '0, seqStatusCheck);
                seqStatusCheck:
                begin
                    frameCount <= frameCount - 8'd1;
                    if (readWord[`ETH_BIT_FRAME_VALID])
                        issueCmd(regRead, `ETH_REG_RXFHBCR, '0, seqFrameLength);
                    else
                        state <= seqFlushRead;   // Invalid frames are only flushed
                end
                seqFrameLength:   // Byte count is not needed, rewind the RX pointer
                    issueCmd(regWrite, `ETH_REG_RXFDPR, `ETH_INIT_RXFDPR, seqDmaRead);
                seqDmaRead:
                    issueCmd(regRead, `ETH_REG_RXQCR, '0, seqDmaSet);
                seqDmaSet:
                begin
                    frameStart <= 1'b1;
                    issueCmd(regWrite, `ETH_REG_RXQCR, readWord | (16'd1 << `ETH_BIT_DMA),
                             seqDmaWord);
                end
                seqDmaWord:
                    if (headerDone)
                        state <= seqFlushRead;
                    else
                        issueCmd(dmaRead, `ETH_REG_RXQCR, '0, seqDmaWord);
                seqFlushRead:
                    issueCmd(regRead, `ETH_REG_RXQCR, '0, seqFlushWrite);
                default:   // Flush clears DMA mode and releases the frame
                    issueCmd(regWrite, `ETH_REG_RXQCR,
                             (readWord & ~(16'd1 << `ETH_BIT_DMA)) | (16'd1 << `ETH_BIT_FLUSH),
                             (frameCount == 8'd0) ? seqIdle : seqFrameStatus);
            endcase
        end
    end

endmodule

// ==== src/ethernetIo.sv ====
//**********************************************************
// KSZ8851 Ethernet I/O
// Sequencer, command port and header decoder above the chip interface
//**********************************************************
`timescale 1ns/1ps

module ethernetIo (
    input  logic                    sysclk,
    input  logic                    reset,
    input  logic                    ETH_IRQn,         // Chip interrupt, active low
    input  logic                    receiveEnabled,
    output logic                    quadRead,
    output logic                    quadWrite,
    input  logic                    initReq,
    output logic                    initAck,
    output logic                    cmdReq,
    input  logic                    cmdAck,
    input  logic                    readValid,
    output logic                    isDMA,
    output logic                    isWrite,
    output logic                    isWord,
    output ethernetIoPkg::regAddr_t RegAddr,
    output ethernetIoPkg::word_t    WriteData,
    input  ethernetIoPkg::word_t    ReadData,
    output logic                    initOK
);
    import ethernetIoPkg::*;

    logic     start;
    logic     busy;
    logic     done;
    logic     dmaWord;
    logic     frameStart;
    logic     headerDone;
    cmdKind_e cmdKind;
    regAddr_t cmdAddr;
    word_t    cmdData;
    word_t    readWord;

    ethSequencer seq0 (
        .sysclk(sysclk), .reset(reset), .initReq(initReq), .ETH_IRQn(ETH_IRQn),
        .receiveEnabled(receiveEnabled), .busy(busy), .done(done), .readWord(readWord),
        .headerDone(headerDone), .initAck(initAck), .initOK(initOK), .start(start),
        .frameStart(frameStart), .cmdKind(cmdKind), .cmdAddr(cmdAddr), .cmdData(cmdData)
    );

    ethCommandPort port0 (
        .sysclk(sysclk), .reset(reset), .start(start), .cmdKind(cmdKind),
        .cmdAddr(cmdAddr), .cmdData(cmdData), .cmdAck(cmdAck), .readValid(readValid),
        .ReadData(ReadData), .busy(busy), .done(done), .dmaWord(dmaWord),
        .cmdReq(cmdReq), .isDMA(isDMA), .isWrite(isWrite), .isWord(isWord),
        .RegAddr(RegAddr), .WriteData(WriteData), .readWord(readWord)
    );

    ethFrameDecoder dec0 (
        .sysclk(sysclk), .reset(reset), .frameStart(frameStart), .done(done),
        .dmaWord(dmaWord), .readWord(readWord), .headerDone(headerDone),
        .quadRead(quadRead), .quadWrite(quadWrite)
    );

endmodule

// ==== tb/ethernetIo_properties.sv ====
//**********************************************************
// Handshake properties
// Bound into ethernetIo, checks the command handshake and reset values
//**********************************************************
`timescale 1ns/1ps

module ethernetIoProperties (
    input logic                    sysclk,
    input logic                    reset,
    input logic                    cmdReq,
    input logic                    cmdAck,
    input logic                    initAck,
    input logic                    initOK,
    input ethernetIoPkg::regAddr_t RegAddr,
    input ethernetIoPkg::word_t    WriteData
);
    int failCount = 0;   // Read by the testbench at the end of the run

    // Request only drops once the lower layer has acknowledged it
    reqHeldForAck: assert property (@(posedge sysclk) disable iff (!reset)
        $fell(cmdReq) |-> $past(cmdAck))
    else
    begin
        $error("cmdReq dropped before cmdAck was high");
        failCount++;
    end

    cmdStable: assert property (@(posedge sysclk) disable iff (!reset)
        cmdReq && $past(cmdReq) |-> $stable(RegAddr) && $stable(WriteData))
    else
    begin
        $error("RegAddr or WriteData changed while cmdReq was high");
        failCount++;
    end

    resetQuiet: assert property (@(posedge sysclk)
        !reset |=> !cmdReq && !initAck && !initOK)   // Outputs idle under reset
    else
    begin
        $error("cmdReq, initAck or initOK high during reset");
        failCount++;
    end

endmodule

bind ethernetIo ethernetIoProperties props0 (
    .sysclk(sysclk), .reset(reset), .cmdReq(cmdReq), .cmdAck(cmdAck),
    .initAck(initAck), .initOK(initOK), .RegAddr(RegAddr), .WriteData(WriteData)
);

// ==== tb/ethernetIoTb.sv ====
//**********************************************************
// KSZ8851 Ethernet I/O testbench
// Chip model with directed init and receive service tests
//**********************************************************
`timescale 1ns/1ps
`include "ethernetIo_macros.svh"

module ethernetIoTb;
    import ethernetIoPkg::*;

    logic        sysclk = 1'b0;
    logic        reset, ETH_IRQn, receiveEnabled, initReq, cmdAck, readValid;
    logic        quadRead, quadWrite, initAck, cmdReq, isDMA, isWrite, isWord, initOK;
    regAddr_t    RegAddr;
    word_t       WriteData, ReadData;

    word_t       regs [256];           // Chip register file
    word_t       dmaQueue [$];         // Words returned by DMA reads
    word_t       statusQueue [$];      // RXFHSR value of each frame
    logic [23:0] writeLog [$];         // {address, data}
    int          dmaReads = 0;
    int          cmdCount = 0;
    logic [15:0] lfsrState = 16'd5;
    regAddr_t    reqAddr;
    word_t       reqData;
    logic        reqWrite;

    ethernetIo dut0 (.*);

    always #5 sysclk = ~sysclk;

    // Near three times the run of about 65 commands of 10 cycles plus reset and idle waits
    initial
    begin
        #20000;
        failRun("Timeout, the tests did not finish within 20000 ns");
    end

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic checkWord(input string name, input word_t got, input word_t exp);
        if (got !== exp)
            failRun($sformatf("Fail at %0d ns: %s = %h, expected %h", $time, name, got, exp));
    endtask

    task automatic checkAddr(input string name, input regAddr_t got, input regAddr_t exp);
        if (got !== exp)
            failRun($sformatf("Fail at %0d ns: %s = %h, expected %h", $time, name, got, exp));
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp)
            failRun($sformatf("Fail at %0d ns: %s = %b, expected %b", $time, name, got, exp));
    endtask

    task automatic checkClass(input string name, input frameClass_e got, input frameClass_e exp);
        if (got !== exp)
            failRun($sformatf("Fail at %0d ns: %s = %s, expected %s", $time, name,
                              got.name(), exp.name()));
    endtask

    task automatic nextCycle();
        @(posedge sysclk);
        #1;
    endtask

    // Taps 16 14 13 11
    function automatic logic lfsrBit();
        lfsrState = {lfsrState[14:0],
                     lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10]};
        return lfsrState[0];
    endfunction

    function automatic word_t randomWord();
        word_t w;
        w = '0;
        for (int i = 0; i < 16; i++)
            w = {w[14:0], lfsrBit()};
        return w;
    endfunction

    function automatic frameClass_e toggledClass(input logic qr0, input logic qw0);
        if (quadRead != qr0)
            return quadReadFrame;
        if (quadWrite != qw0)
            return quadWriteFrame;
        return otherFrame;
    endfunction

    // Skipped words, two MAC addresses, then the length word
    task automatic pushFrame(input word_t length);
        repeat (`ETH_SKIP_WORDS) dmaQueue.push_back(16'h0000);
        repeat (`ETH_HEADER_WORDS - 1) dmaQueue.push_back(randomWord());
        dmaQueue.push_back(length);
    endtask

    task automatic expectWrite(input regAddr_t addr, input word_t data);
        logic [23:0] entry;
        if (writeLog.size() == 0)
            failRun($sformatf("Missing write of %h to register %h", data, addr));
        else
        begin
            entry = writeLog.pop_front();
            checkAddr("write address", entry[23:16], addr);
            checkWord("write data", entry[15:0], data);
        end
    endtask

    task automatic noMoreWrites();
        if (writeLog.size() != 0)
            failRun("Register write beyond the expected sequence");
    endtask

    // Service is over once cmdReq has stayed low for a while
    task automatic waitQuiet();
        int quiet;
        quiet = 0;
        while (quiet < 20)
        begin
            nextCycle();
            quiet = cmdReq ? 0 : quiet + 1;
        end
    endtask

    task automatic serviceInterrupt(output logic qr0, output logic qw0);
        qr0 = quadRead;
        qw0 = quadWrite;
        writeLog.delete();
        dmaReads = 0;
        cmdCount = 0;
        receiveEnabled = 1'b1;
        ETH_IRQn = 1'b0;
        while (!cmdReq)
            nextCycle();
        ETH_IRQn = 1'b1;   // Chip releases the line once service starts
        waitQuiet();
    endtask

    // KSZ8851 model acks 2 cycles after cmdReq and drops the ack 2 cycles after cmdReq falls
    always
    begin
        nextCycle();
        if (cmdReq)
        begin
            readValid = 1'b0;
            cmdCount++;
            reqAddr  = RegAddr;
            reqWrite = isWrite;
            checkBit("isWord", isWord, 1'b1);
            if (isWrite)
            begin
                writeLog.push_back({RegAddr, WriteData});
                if (RegAddr != `ETH_REG_ISR && RegAddr != `ETH_REG_RXQCR)
                    regs[RegAddr] = WriteData;   // ISR and RXQCR bits clear themselves
            end
            else if (isDMA)
            begin
                dmaReads++;
                if (dmaQueue.size() == 0)
                    failRun("DMA read with no frame data left in the chip model");
                else
                    reqData = dmaQueue.pop_front();
            end
            else if (RegAddr == `ETH_REG_RXFHSR && statusQueue.size() != 0)
                reqData = statusQueue.pop_front();
            else
                reqData = regs[RegAddr];
            repeat (2) @(posedge sysclk);
            #1 cmdAck = 1'b1;
            while (cmdReq)
                nextCycle();
            repeat (2) @(posedge sysclk);
            #1 cmdAck = 1'b0;
            readValid = !reqWrite;
            ReadData  = reqData;
        end
    end

    task automatic initGoodChip();
        regs[`ETH_REG_CHIPID] = 16'h8872;
        writeLog.delete();
        checkBit("initOK", initOK, 1'b0);
        initReq = 1'b1;
        nextCycle();
        checkBit("initAck", initAck, 1'b1);
        initReq = 1'b0;
        while (initAck)
            nextCycle();
        while (!initOK)
            nextCycle();
        expectWrite(`ETH_REG_MARL, `ETH_MAC_LOW);
        expectWrite(`ETH_REG_MARM, `ETH_MAC_MID);
        expectWrite(`ETH_REG_MARH, `ETH_MAC_HIGH);
        expectWrite(`ETH_REG_TXFDPR, 16'h4000);
        expectWrite(`ETH_REG_TXCR, 16'h01EE);
        expectWrite(`ETH_REG_RXFDPR, 16'h5000);
        expectWrite(`ETH_REG_RXFCTR, 16'h0001);
        expectWrite(`ETH_REG_RXCR1, 16'h7CE0);
        expectWrite(`ETH_REG_RXQCR, 16'h0020);
        expectWrite(`ETH_REG_ISR, 16'hFFFF);
        expectWrite(`ETH_REG_IER, 16'h2000);
        expectWrite(`ETH_REG_TXCR, 16'h01EF);    // TX enable bit set
        expectWrite(`ETH_REG_RXCR1, 16'h7CE1);
        noMoreWrites();
    endtask

    task automatic initBadChip();
        regs[`ETH_REG_CHIPID] = 16'h1230;
        writeLog.delete();
        cmdCount = 0;
        initReq = 1'b1;
        nextCycle();
        checkBit("initAck", initAck, 1'b1);
        initReq = 1'b0;
        while (initAck)
            nextCycle();
        waitQuiet();
        checkBit("initOK", initOK, 1'b0);
        checkWord("command count", 16'(cmdCount), 16'd1);
        noMoreWrites();
    endtask

    task automatic rxSingleFrame();
        logic qr0, qw0;
        regs[`ETH_REG_ISR]    = 16'h2004;   // RXIS pending
        regs[`ETH_REG_RXFCTR] = 16'h0101;
        regs[`ETH_REG_RXQCR]  = 16'h0020;
        statusQueue.push_back(16'h8040);
        pushFrame(`ETH_LEN_QREAD);
        serviceInterrupt(qr0, qw0);
        expectWrite(`ETH_REG_ISR, 16'h2004);
        expectWrite(`ETH_REG_RXFDPR, 16'h5000);
        expectWrite(`ETH_REG_RXQCR, 16'h0028);   // DMA on
        expectWrite(`ETH_REG_RXQCR, 16'h0021);   // Flush with DMA off
        noMoreWrites();
        checkWord("DMA read count", 16'(dmaReads), 16'd10);
        checkClass("frame class", toggledClass(qr0, qw0), quadReadFrame);
        checkBit("quadWrite", quadWrite, qw0);
    endtask

    task automatic rxTwoFrames();
        logic qr0, qw0;
        regs[`ETH_REG_RXFCTR] = 16'h0201;
        regs[`ETH_REG_RXQCR]  = 16'h0028;   // Reads back with the DMA bit set
        statusQueue.push_back(16'h8040);
        statusQueue.push_back(16'h0040);   // Second frame invalid
        pushFrame(`ETH_LEN_QWRITE);
        serviceInterrupt(qr0, qw0);
        expectWrite(`ETH_REG_ISR, 16'h2004);
        expectWrite(`ETH_REG_RXFDPR, 16'h5000);
        expectWrite(`ETH_REG_RXQCR, 16'h0028);
        expectWrite(`ETH_REG_RXQCR, 16'h0021);
        expectWrite(`ETH_REG_RXQCR, 16'h0021);
        noMoreWrites();
        checkWord("DMA read count", 16'(dmaReads), 16'd10);
        if (dmaQueue.size() != 0)
            failRun("Frame data left unread in the chip model");
        checkClass("frame class", toggledClass(qr0, qw0), quadWriteFrame);
        checkBit("quadRead", quadRead, qr0);
    endtask

    task automatic rxNoService();
        logic qr0, qw0;
        regs[`ETH_REG_ISR] = 16'h0004;   // RXIS clear
        serviceInterrupt(qr0, qw0);
        checkWord("command count", 16'(cmdCount), 16'd1);
        checkAddr("command address", reqAddr, `ETH_REG_ISR);
        noMoreWrites();
        checkWord("DMA read count", 16'(dmaReads), 16'd0);
        checkClass("frame class", toggledClass(qr0, qw0), otherFrame);
        receiveEnabled = 1'b0;
        cmdCount = 0;
        ETH_IRQn = 1'b0;
        repeat (40) nextCycle();
        ETH_IRQn = 1'b1;
        checkWord("command count", 16'(cmdCount), 16'd0);
        checkClass("frame class", toggledClass(qr0, qw0), otherFrame);
    endtask

    initial
    begin
        reset = 1'b0;
        ETH_IRQn = 1'b1;
        receiveEnabled = 1'b0;
        initReq = 1'b0;
        cmdAck = 1'b0;
        readValid = 1'b0;
        ReadData = '0;
        for (int a = 0; a < 256; a++)
            regs[a] = {~8'(a), 8'(a)};
        repeat (16) @(posedge sysclk);
        #1 reset = 1'b1;
        initGoodChip();
        initBadChip();
        rxSingleFrame();
        rxTwoFrames();
        rxNoService();
        if (dut0.props0.failCount == 0)
        begin
            $display("NO ERRORS");
            $finish;
        end
        else
            failRun("A bound handshake assertion failed during the run");
    end

endmodule

// ==== ethernetIo.f ====
+incdir+src
src/ethernetIoPkg.sv
src/ethFrameDecoder.sv
src/ethCommandPort.sv
src/ethSequencer.sv
src/ethernetIo.sv
tb/ethernetIo_properties.sv
tb/ethernetIoTb.sv

// ==== Makefile ====
TOP = ethernetIoTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f ethernetIo.f --top-module $(TOP)

run: compile
	-./obj_dir/V$(TOP) > sim.log 2>&1
	@cat sim.log
	@grep -q "^NO ERRORS$$" sim.log

clean:
	rm -rf obj_dir sim.log
